/* logic/crc16_unit.sv */
// Serial Modbus CRC-16
// Folds one byte per enabled clock into the running remainder

`timescale 1ns/1ps
`default_nettype none

module crc16_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          clr,
  input  logic                          en,
  input  logic [modbus_pkg::BYTE_W-1:0] data,
  output logic [modbus_pkg::WORD_W-1:0] crc
);
  import modbus_pkg::*;

  logic [WORD_W-1:0] crc_nxt;

  // Eight LSB-first shift steps unrolled within one cycle
  always_comb begin
    crc_nxt = crc ^ WORD_W'(data);
    for (int i = 0; i < BYTE_W; i++) begin
      crc_nxt = crc_nxt[0] ? ((crc_nxt >> 1) ^ CRC_POLY) : (crc_nxt >> 1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clr) begin
      crc <= CRC_INIT;
    end else if (en) begin
      crc <= crc_nxt;
    end
  end

endmodule

`default_nettype wire

/* logic/frame_byte_counter.sv */
// Frame byte counter
// Receive length, then word index, then transmit index

`timescale 1ns/1ps
`default_nettype none

module frame_byte_counter #(
  parameter int BUF_MAX = 256
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         clr,
  input  logic                         inc,
  output logic [$clog2(BUF_MAX+1)-1:0] count
);

  // Clear wins over increment
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      count <= '0;
    end else if (inc) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/frame_ctrl.sv */
// Modbus RTU frame controller
// Sequences collect, check, execute and send for one request at a time

`timescale 1ns/1ps
`default_nettype none

module frame_ctrl #(
  parameter int BUF_MAX = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rx_b_v,
  input  logic                          frame_start,
  input  logic                          frame_end,
  input  logic                          tx_b_rdy,
  input  logic [$clog2(BUF_MAX+1)-1:0]  count,
  input  logic [modbus_pkg::WORD_W-1:0] crc,
  input  modbus_pkg::func_code_e        func,
  input  logic [modbus_pkg::WORD_W-1:0] qty,
  input  logic [modbus_pkg::WORD_W-1:0] resp_len,
  output logic                          cnt_clr,
  output logic                          cnt_inc,
  output logic                          buf_we,
  output logic                          reg_we,
  output logic                          crc_clr,
  output logic                          crc_en,
  output logic                          crc_sel_tx,
  output logic                          tx_b_v,
  output logic                          stat_crc_err
);
  import modbus_pkg::*;

  ctrl_state_e       state;
  ctrl_state_e       state_nxt;
  logic              chk_phase;
  logic              len_ok;
  logic              crc_ok;
  logic              fc_ok;
  logic              exec_done;
  logic              room;
  logic [WORD_W-1:0] cnt_w;

  assign cnt_w = WORD_W'(count);
  assign room  = count < BUF_MAX;

  // ============================================================
  // Next state and strobes
  // ============================================================
  always_comb begin
    state_nxt  = state;
    cnt_clr    = 1'b0;
    cnt_inc    = 1'b0;
    buf_we     = 1'b0;
    reg_we     = 1'b0;
    crc_clr    = 1'b0;
    crc_en     = 1'b0;
    crc_sel_tx = 1'b0;
    tx_b_v     = 1'b0;
    exec_done  = 1'b0;
    case (state)
      ST_IDLE: begin
        cnt_clr = 1'b1;
        if (frame_start) begin
          crc_clr   = 1'b1;
          state_nxt = ST_COLLECT;
        end
      end
      ST_COLLECT: begin
        // Bytes past the buffer end are dropped
        buf_we  = rx_b_v && room;
        cnt_inc = rx_b_v && room;
        crc_en  = rx_b_v && room;
        if (frame_end) begin
          state_nxt = ST_CHECK;
        end
      end
      ST_CHECK: begin
        if (chk_phase) begin
          if (len_ok && crc_ok && fc_ok) begin
            cnt_clr   = 1'b1;
            state_nxt = ST_EXEC;
          end else begin
            state_nxt = ST_IDLE;
          end
        end
      end
      ST_EXEC: begin
        case (func)
          FC_WRITE_SINGLE: begin
            reg_we    = 1'b1;
            exec_done = 1'b1;
          end
          FC_WRITE_MULTIPLE: begin
            // One word per cycle, count is the word index
            reg_we    = cnt_w < qty;
            exec_done = (cnt_w + 1) >= qty;
          end
          default: begin
            exec_done = 1'b1;
          end
        endcase
        if (exec_done) begin
          cnt_clr   = 1'b1;
          crc_clr   = 1'b1;
          state_nxt = ST_SEND;
        end else begin
          cnt_inc = 1'b1;
        end
      end
      ST_SEND: begin
        crc_sel_tx = 1'b1;
        if (cnt_w == resp_len) begin
          state_nxt = ST_IDLE;
        end else if (tx_b_rdy) begin
          tx_b_v  = 1'b1;
          cnt_inc = 1'b1;
          crc_en  = 1'b1;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // ============================================================
  // State and status registers
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      chk_phase    <= 1'b0;
      stat_crc_err <= 1'b0;
    end else begin
      state     <= state_nxt;
      chk_phase <= (state == ST_CHECK) && !chk_phase;
      // Short frames are dropped silently, the flag is for CRC faults only
      if (state == ST_CHECK && chk_phase && len_ok && !crc_ok) begin
        stat_crc_err <= 1'b1;
      end
    end
  end

  // First check cycle samples the verdicts, second one acts on them
  always_ff @(posedge clk) begin
    if (state == ST_CHECK && !chk_phase) begin
      len_ok <= count >= MIN_FRAME_LEN;
      crc_ok <= crc == '0;
      fc_ok  <= func inside {FC_READ_HOLDING, FC_WRITE_SINGLE, FC_WRITE_MULTIPLE};
    end
  end

endmodule

`default_nettype wire

/* logic/holding_regs.sv */
// Holding register bank
// REG_WORDS words, one synchronous write port and one asynchronous read port

`timescale 1ns/1ps
`default_nettype none

module holding_regs #(
  parameter int REG_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we,
  input  logic [$clog2(REG_WORDS)-1:0]  waddr,
  input  logic [modbus_pkg::WORD_W-1:0] wdata,
  input  logic [$clog2(REG_WORDS)-1:0]  raddr,
  output logic [modbus_pkg::WORD_W-1:0] rdata
);
  import modbus_pkg::*;

  logic [WORD_W-1:0] regs [REG_WORDS];

  // Unwritten registers read as zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata = regs[raddr];

endmodule

`default_nettype wire

/* logic/modbus_pkg.sv */
// Modbus RTU slave shared definitions
// Frame widths, CRC-16 constants, function codes and controller states

`default_nettype none

package modbus_pkg;

  // ============================================================
  // Widths
  // ============================================================
  localparam int BYTE_W = 8;
  localparam int WORD_W = 16;

  // ============================================================
  // CRC-16 (Modbus, reflected)
  // ============================================================
  localparam logic [WORD_W-1:0] CRC_INIT = 16'hFFFF;
  localparam logic [WORD_W-1:0] CRC_POLY = 16'hA001;

  // Address, function and two CRC bytes
  localparam int MIN_FRAME_LEN = 4;

  // Supported function codes
  typedef enum logic [7:0] {
    FC_READ_HOLDING   = 8'h03,
    FC_WRITE_SINGLE   = 8'h06,
    FC_WRITE_MULTIPLE = 8'h10
  } func_code_e;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_COLLECT = 3'd1,
    ST_CHECK   = 3'd2,
    ST_EXEC    = 3'd3,
    ST_SEND    = 3'd4
  } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/modbus_slave_top.sv */
// Modbus RTU slave top level
// Connects the frame controller, byte counter, CRC unit, request buffer,
// holding registers and response builder

`timescale 1ns/1ps
`default_nettype none

module modbus_slave_top #(
  parameter int REG_WORDS = 64,
  parameter int BUF_MAX   = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [modbus_pkg::BYTE_W-1:0] rx_b,
  input  logic                          rx_b_v,
  input  logic                          frame_start,
  input  logic                          frame_end,
  input  logic                          tx_b_rdy,
  input  logic [modbus_pkg::WORD_W-1:0] cfg_map_base,
  output logic [modbus_pkg::BYTE_W-1:0] tx_b,
  output logic                          tx_b_v,
  output logic                          stat_crc_err
);
  import modbus_pkg::*;

  localparam int CNT_W = $clog2(BUF_MAX + 1);
  localparam int AW    = $clog2(BUF_MAX);
  localparam int IDX_W = $clog2(REG_WORDS);

  logic              cnt_clr;
  logic              cnt_inc;
  logic              buf_we;
  logic              reg_we;
  logic              crc_clr;
  logic              crc_en;
  logic              crc_sel_tx;
  logic              crc_step;
  logic              payload;
  logic [CNT_W-1:0]  count;
  logic [WORD_W-1:0] count_word;
  logic [WORD_W-1:0] crc;
  logic [BYTE_W-1:0] crc_data;
  func_code_e        func;
  logic [WORD_W-1:0] start_addr;
  logic [WORD_W-1:0] qty;
  logic [WORD_W-1:0] resp_len;
  logic [WORD_W-1:0] word_ptr;
  logic [AW-1:0]     raddr_a;
  logic [AW-1:0]     raddr_b;
  logic [BYTE_W-1:0] rdata_a;
  logic [BYTE_W-1:0] rdata_b;
  logic [IDX_W-1:0]  reg_raddr;
  logic [WORD_W-1:0] reg_rdata;

  assign count_word = WORD_W'(count);

  // CRC runs over received bytes, then over the outgoing payload only
  assign crc_data = crc_sel_tx ? tx_b : rx_b;
  assign crc_step = crc_en && (payload || !crc_sel_tx);

  // Buffer offset of the word being written in the FC06 value or the FC16 data block
  assign word_ptr = (func == FC_WRITE_SINGLE) ? WORD_W'(4) : WORD_W'(7) + (count_word << 1);
  assign raddr_a  = crc_sel_tx ? count[AW-1:0] : word_ptr[AW-1:0];
  assign raddr_b  = AW'(word_ptr + WORD_W'(1));

  frame_ctrl #(.BUF_MAX(BUF_MAX)) u_frame_ctrl (
    .clk(clk), .rst(rst), .rx_b_v(rx_b_v), .frame_start(frame_start),
    .frame_end(frame_end), .tx_b_rdy(tx_b_rdy), .count(count), .crc(crc),
    .func(func), .qty(qty), .resp_len(resp_len), .cnt_clr(cnt_clr),
    .cnt_inc(cnt_inc), .buf_we(buf_we), .reg_we(reg_we), .crc_clr(crc_clr),
    .crc_en(crc_en), .crc_sel_tx(crc_sel_tx), .tx_b_v(tx_b_v),
    .stat_crc_err(stat_crc_err)
  );

  frame_byte_counter #(.BUF_MAX(BUF_MAX)) u_frame_byte_counter (
    .clk(clk), .rst(rst), .clr(cnt_clr), .inc(cnt_inc), .count(count)
  );

  crc16_unit u_crc16_unit (
    .clk(clk), .rst(rst), .clr(crc_clr), .en(crc_step), .data(crc_data), .crc(crc)
  );

  rx_frame_buffer #(.BUF_MAX(BUF_MAX)) u_rx_frame_buffer (
    .clk(clk), .we(buf_we), .waddr(count[AW-1:0]), .wdata(rx_b),
    .raddr_a(raddr_a), .raddr_b(raddr_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
    .func(func), .start_addr(start_addr), .qty(qty)
  );

  // Reads and writes never overlap, so one register index serves both ports
  holding_regs #(.REG_WORDS(REG_WORDS)) u_holding_regs (
    .clk(clk), .rst(rst), .we(reg_we), .waddr(reg_raddr), .wdata({rdata_a, rdata_b}),
    .raddr(reg_raddr), .rdata(reg_rdata)
  );

  response_mux #(.REG_WORDS(REG_WORDS)) u_response_mux (
    .func(func), .start_addr(start_addr), .qty(qty), .cfg_map_base(cfg_map_base),
    .count(count_word), .echo_byte(rdata_a), .rdata(reg_rdata), .crc(crc),
    .tx_byte(tx_b), .reg_raddr(reg_raddr), .resp_len(resp_len), .payload(payload)
  );

endmodule

`default_nettype wire

/* logic/response_mux.sv */
// Response byte builder
// Picks the outgoing byte for each transmit index and sizes the response

`timescale 1ns/1ps
`default_nettype none

module response_mux #(
  parameter int REG_WORDS = 64
) (
  input  modbus_pkg::func_code_e         func,
  input  logic [modbus_pkg::WORD_W-1:0]  start_addr,
  input  logic [modbus_pkg::WORD_W-1:0]  qty,
  input  logic [modbus_pkg::WORD_W-1:0]  cfg_map_base,
  input  logic [modbus_pkg::WORD_W-1:0]  count,
  input  logic [modbus_pkg::BYTE_W-1:0]  echo_byte,
  input  logic [modbus_pkg::WORD_W-1:0]  rdata,
  input  logic [modbus_pkg::WORD_W-1:0]  crc,
  output logic [modbus_pkg::BYTE_W-1:0]  tx_byte,
  output logic [$clog2(REG_WORDS)-1:0]   reg_raddr,
  output logic [modbus_pkg::WORD_W-1:0]  resp_len,
  output logic                           payload
);
  import modbus_pkg::*;

  localparam int IDX_W = $clog2(REG_WORDS);

  logic              is_read;
  logic [WORD_W-1:0] data_off;
  logic [WORD_W-1:0] word_idx;
  logic [WORD_W-1:0] reg_off;
  logic [WORD_W-1:0] byte_cnt;

  assign is_read = func == FC_READ_HOLDING;

  // FC03 data starts at byte 3, two bytes per word, high byte first
  assign data_off = count - WORD_W'(3);

  // Writes use count directly as the word index during execute
  assign word_idx = is_read ? (data_off >> 1) : count;

  // ============================================================
  // Register index, wrapped into the bank
  // ============================================================
  assign reg_off   = start_addr - cfg_map_base + word_idx;
  assign reg_raddr = IDX_W'(reg_off % REG_WORDS);

  assign byte_cnt = qty << 1;
  assign resp_len = is_read ? (WORD_W'(5) + byte_cnt) : WORD_W'(8);
  assign payload  = count < (resp_len - WORD_W'(2));

  always_comb begin
    if (!payload) begin
      // CRC goes out low byte first
      tx_byte = (count == resp_len - WORD_W'(2)) ? crc[7:0] : crc[15:8];
    end else if (is_read && count == WORD_W'(2)) begin
      tx_byte = byte_cnt[BYTE_W-1:0];
    end else if (is_read && count > WORD_W'(2)) begin
      tx_byte = data_off[0] ? rdata[7:0] : rdata[15:8];
    end else begin
      // Header echo of address, function, start and quantity or value
      tx_byte = echo_byte;
    end
  end

endmodule

`default_nettype wire

/* logic/rx_frame_buffer.sv */
// Request byte store
// One write port, two asynchronous read ports and decoded header fields

`timescale 1ns/1ps
`default_nettype none

module rx_frame_buffer #(
  parameter int BUF_MAX = 256
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(BUF_MAX)-1:0]    waddr,
  input  logic [modbus_pkg::BYTE_W-1:0] wdata,
  input  logic [$clog2(BUF_MAX)-1:0]    raddr_a,
  input  logic [$clog2(BUF_MAX)-1:0]    raddr_b,
  output logic [modbus_pkg::BYTE_W-1:0] rdata_a,
  output logic [modbus_pkg::BYTE_W-1:0] rdata_b,
  output modbus_pkg::func_code_e        func,
  output logic [modbus_pkg::WORD_W-1:0] start_addr,
  output logic [modbus_pkg::WORD_W-1:0] qty
);
  import modbus_pkg::*;

  logic [BYTE_W-1:0] mem [BUF_MAX];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata_a = mem[raddr_a];
  assign rdata_b = mem[raddr_b];

  // Fixed header layout with address and function, then big endian start and qty
  assign func       = func_code_e'(mem[1]);
  assign start_addr = {mem[2], mem[3]};
  assign qty        = {mem[4], mem[5]};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the Modbus slave testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_modbus_slave \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Build or run did not complete, see build.log and sim.log"

grep -q "ALL TESTS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* test/modbus_input.txt */
# mode(0 good CRC, 1 corrupted CRC, 2 no CRC) n_req req_bytes n_resp resp_bytes crc_err
# counts in decimal, bytes in hex without CRC, n_resp 0 means no response, map base 0100
0 6 11 06 01 01 12 34   6 11 06 01 01 12 34   0
0 6 11 03 01 00 00 03   9 11 03 06 00 00 12 34 00 00   0
0 11 11 10 01 02 00 02 04 AB CD 56 78   6 11 10 01 02 00 02   0
0 6 11 03 01 00 00 04   11 11 03 08 00 00 12 34 AB CD 56 78   0
0 6 11 04 01 00 00 01   0   0
2 3 11 03 00   0   0
1 6 11 06 01 00 FF FF   0   1
0 6 11 03 01 00 00 02   7 11 03 04 00 00 12 34   1
0 6 11 06 00 FF 0B EE   6 11 06 00 FF 0B EE   1
0 6 11 03 00 FF 00 03   9 11 03 06 0B EE 00 00 12 34   1
0 13 11 10 01 10 00 03 06 00 01 00 02 00 03   6 11 10 01 10 00 03   1
0 6 11 03 01 10 00 03   9 11 03 06 00 01 00 02 00 03   1
0 6 11 03 01 20 00 02   7 11 03 04 00 00 00 00   1

/* test/tb_modbus_slave.sv */
// Modbus RTU slave testbench
// Replays request frames from the data file under random back-pressure
// and compares every response byte and the CRC error flag

`timescale 1ns/1ps
`default_nettype none

module tb_modbus_slave;
  import modbus_pkg::*;

  localparam int    CLK_HALF   = 20;
  localparam int    RST_CYCLES = 16;
  localparam int    REC_CYCLES = 400;
  localparam string DATA_FILE  = "test/modbus_input.txt";

  logic              clk;
  logic              rst;
  logic [BYTE_W-1:0] rx_b;
  logic              rx_b_v;
  logic              frame_start;
  logic              frame_end;
  logic              tx_b_rdy;
  logic [WORD_W-1:0] cfg_map_base;
  logic [BYTE_W-1:0] tx_b;
  logic              tx_b_v;
  logic              stat_crc_err;

  // Flattened records from the data file
  int                mode_q[$];
  int                req_base_q[$];
  int                req_n_q[$];
  int                resp_base_q[$];
  int                resp_n_q[$];
  logic              err_q[$];
  logic [BYTE_W-1:0] req_q[$];
  logic [BYTE_W-1:0] resp_q[$];
  logic [BYTE_W-1:0] tx_seen[$];
  int                num_records;
  logic              loaded;
  int                errors_value;
  int                errors_other;

  modbus_slave_top #(.REG_WORDS(64), .BUF_MAX(256)) u_modbus_slave_top (
    .clk(clk), .rst(rst), .rx_b(rx_b), .rx_b_v(rx_b_v), .frame_start(frame_start),
    .frame_end(frame_end), .tx_b_rdy(tx_b_rdy), .cfg_map_base(cfg_map_base),
    .tx_b(tx_b), .tx_b_v(tx_b_v), .stat_crc_err(stat_crc_err)
  );

  always #CLK_HALF clk = ~clk;

  // Random back-pressure with ready high about 60 percent of the time
  initial begin
    void'($urandom(97998));
    forever begin
      @(posedge clk);
      #2;
      tx_b_rdy = ($urandom_range(9) < 6);
    end
  end

  // Every strobed output byte is sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && tx_b_v) begin
      tx_seen.push_back(tx_b);
    end
  end

  // Bit-serial Modbus CRC that shifts each byte in LSB first
  function automatic logic [15:0] crc_fold(input logic [15:0] crc_in, input logic [7:0] data);
    logic [15:0] c;
    logic        fb;
    c = crc_in;
    for (int i = 0; i < 8; i++) begin
      fb = c[0] ^ data[i];
      c  = c >> 1;
      if (fb) begin
        c = c ^ 16'hA001;
      end
    end
    return c;
  endfunction

  task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp_v,
                            input logic [BYTE_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERROR at %0t ns: %s expected %02h, got %02h", $time, name, exp_v, act_v);
      errors_value++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
      errors_value++;
    end
  endtask

  task automatic load_records();
    int                fd;
    int                code;
    int                mode;
    int                n;
    int                e;
    logic [BYTE_W-1:0] b;
    string             line;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", DATA_FILE);
      errors_other++;
      return;
    end
    // Two header lines describe the columns
    code = $fgets(line, fd);
    code = $fgets(line, fd);
    while ($fscanf(fd, "%d", mode) == 1) begin
      mode_q.push_back(mode);
      code = $fscanf(fd, "%d", n);
      req_base_q.push_back(req_q.size());
      req_n_q.push_back(n);
      for (int i = 0; i < n; i++) begin
        code = $fscanf(fd, "%h", b);
        req_q.push_back(b);
      end
      code = $fscanf(fd, "%d", n);
      resp_base_q.push_back(resp_q.size());
      resp_n_q.push_back(n);
      for (int i = 0; i < n; i++) begin
        code = $fscanf(fd, "%h", b);
        resp_q.push_back(b);
      end
      code = $fscanf(fd, "%d", e);
      err_q.push_back(e[0]);
    end
    $fclose(fd);
  endtask

  task automatic drive_byte(input logic [BYTE_W-1:0] b);
    rx_b   = b;
    rx_b_v = 1'b1;
    @(posedge clk);
    #2;
    rx_b_v = 1'b0;
  endtask

  // Mode 0 appends a good CRC, mode 1 a corrupted one, mode 2 none
  task automatic send_frame(input int rec);
    logic [15:0] crc;
    crc = 16'hFFFF;
    @(posedge clk);
    #2;
    frame_start = 1'b1;
    @(posedge clk);
    #2;
    frame_start = 1'b0;
    for (int i = 0; i < req_n_q[rec]; i++) begin
      crc = crc_fold(crc, req_q[req_base_q[rec] + i]);
      drive_byte(req_q[req_base_q[rec] + i]);
    end
    if (mode_q[rec] == 1) begin
      crc = crc ^ 16'h005A;
    end
    if (mode_q[rec] != 2) begin
      drive_byte(crc[7:0]);
      drive_byte(crc[15:8]);
    end
    frame_end = 1'b1;
    @(posedge clk);
    #2;
    frame_end = 1'b0;
  endtask

  task automatic check_response(input int rec);
    logic [15:0]       crc;
    logic [BYTE_W-1:0] exp_b;
    int                n;
    int                total;
    int                waited;
    n      = resp_n_q[rec];
    total  = (n == 0) ? 0 : n + 2;
    waited = 0;
    crc    = 16'hFFFF;
    // Check takes two cycles, so a dropped frame is quiet well inside this window
    while (tx_seen.size() < total && waited < REC_CYCLES / 2) begin
      @(posedge clk);
      #5;
      waited++;
    end
    repeat ((total == 0) ? 20 : 4) begin
      @(posedge clk);
      #5;
    end
    for (int i = 0; i < total && i < tx_seen.size(); i++) begin
      if (i < n) begin
        exp_b = resp_q[resp_base_q[rec] + i];
        crc   = crc_fold(crc, exp_b);
      end else begin
        exp_b = (i == n) ? crc[7:0] : crc[15:8];
      end
      check_byte("tx_b", exp_b, tx_seen[i]);
    end
    if (tx_seen.size() < total) begin
      $display("Record %0d: only %0d of %0d response bytes arrived", rec, tx_seen.size(),
               total);
      errors_other++;
    end else if (tx_seen.size() > total) begin
      $display("Record %0d: %0d response bytes arrived where %0d were expected", rec,
               tx_seen.size(), total);
      errors_other++;
    end
    check_flag("stat_crc_err", err_q[rec], stat_crc_err);
    tx_seen.delete();
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    logic [BYTE_W-1:0] known [6];
    logic [15:0]       crc_chk;
    clk          = 1'b0;
    rst          = 1'b1;
    rx_b         = '0;
    rx_b_v       = 1'b0;
    frame_start  = 1'b0;
    frame_end    = 1'b0;
    tx_b_rdy     = 1'b0;
    cfg_map_base = 16'h0100;
    errors_value = 0;
    errors_other = 0;
    loaded       = 1'b0;
    load_records();
    num_records = mode_q.size();
    loaded      = 1'b1;
    // Reference CRC against the well known frame 01 03 00 00 00 0A -> C5 CD
    known   = '{8'h01, 8'h03, 8'h00, 8'h00, 8'h00, 8'h0A};
    crc_chk = 16'hFFFF;
    foreach (known[i]) begin
      crc_chk = crc_fold(crc_chk, known[i]);
    end
    if (crc_chk != 16'hCDC5) begin
      $display("Reference CRC gives %04h for the known frame instead of CDC5", crc_chk);
      errors_other++;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int r = 0; r < num_records; r++) begin
      send_frame(r);
      check_response(r);
    end
    $display("Records: %0d, value errors: %0d, other errors: %0d", num_records,
             errors_value, errors_other);
    if (errors_value == 0 && errors_other == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the record count
  initial begin
    wait (loaded);
    #((num_records + 1) * REC_CYCLES * 2 * CLK_HALF);
    $display("Watchdog expired before all records were replayed");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/modbus_pkg.sv
logic/frame_byte_counter.sv
logic/crc16_unit.sv
logic/rx_frame_buffer.sv
logic/holding_regs.sv
logic/response_mux.sv
logic/frame_ctrl.sv
logic/modbus_slave_top.sv
test/tb_modbus_slave.sv
